//--- vc_router_macros.svh
// vc router parameters
// port and vc counts, fifo depth and field widths shared by all blocks

`ifndef VC_ROUTER_MACROS_SVH
`define VC_ROUTER_MACROS_SVH

// north, east, south, west, local
`define VR_NUM_PORTS 5

// virtual channels per port
`define VR_NUM_VC 2

// fifo depth per vc, also the initial credit count
`define VR_VC_DEPTH 2

// field widths
`define VR_COORD_W 3
`define VR_PAYLOAD_W 16
`define VR_VC_ID_W 1
`define VR_CREDIT_W 2

`endif

//--- source/vc_router_pkg.sv
// vc router package
// flit layout and port direction encoding

`default_nettype none

`include "vc_router_macros.svh"

package vc_router_pkg;

  // ==============================
  // port directions
  // ==============================

  // index order matches the router port numbering
  typedef enum logic [2:0] {
    dir_north = 3'd0,
    dir_east  = 3'd1,
    dir_south = 3'd2,
    dir_west  = 3'd3,
    dir_local = 3'd4
  } port_dir_e;

  // ==============================
  // flit
  // ==============================

  // single-flit packet, vc field is rewritten at each hop
  typedef struct packed {
    logic [`VR_VC_ID_W-1:0]   vc;
    logic [`VR_COORD_W-1:0]   dst_x;
    logic [`VR_COORD_W-1:0]   dst_y;
    port_dir_e                src_port;
    logic [`VR_PAYLOAD_W-1:0] payload;
  } flit_t;

endpackage

`default_nettype wire

//--- source/vc_req_if.sv
// switch request interface
// one input port's request towards the switch allocator and its grant

`timescale 1ns/1ps
`default_nettype none

`include "vc_router_macros.svh"

interface vc_req_if;
  import vc_router_pkg::*;

  logic                     req_v;
  logic [`VR_NUM_PORTS-1:0] req_dir_oh;
  flit_t                    req_flit;
  logic                     grant;
  logic [`VR_VC_ID_W-1:0]   grant_vc;

  modport requester (output req_v, output req_dir_oh, output req_flit,
                     input grant, input grant_vc);

  modport allocator (input req_v, input req_dir_oh, input req_flit,
                     output grant, output grant_vc);

endinterface

`default_nettype wire

//--- source/vc_input_port.sv
// vc input port
// per-vc flit fifos, xy route of each head flit, round-robin vc choice
// and credit return towards the upstream sender

`timescale 1ns/1ps
`default_nettype none

`include "vc_router_macros.svh"

module vc_input_port (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic [`VR_COORD_W-1:0] my_x_i,
  input  logic [`VR_COORD_W-1:0] my_y_i,
  input  logic                   data_v_i,
  input  vc_router_pkg::flit_t   data_i,
  output logic                   credit_v_o,
  output logic [`VR_VC_ID_W-1:0] credit_id_o,
  vc_req_if.requester            req
);
  import vc_router_pkg::*;

  localparam int PTR_W = (`VR_VC_DEPTH > 1) ? $clog2(`VR_VC_DEPTH) : 1;
  localparam int CNT_W = `VR_CREDIT_W;
  localparam int VC_W  = `VR_VC_ID_W;

  flit_t                    mem [`VR_NUM_VC][`VR_VC_DEPTH];
  logic [PTR_W-1:0]         wr_ptr [`VR_NUM_VC];
  logic [PTR_W-1:0]         rd_ptr [`VR_NUM_VC];
  logic [CNT_W-1:0]         count [`VR_NUM_VC];
  logic [`VR_NUM_VC-1:0]    push;
  logic [`VR_NUM_VC-1:0]    pop;
  logic [`VR_NUM_VC-1:0]    vc_empty;
  flit_t                    head_flit [`VR_NUM_VC];
  logic [`VR_NUM_PORTS-1:0] head_dir [`VR_NUM_VC];
  logic [VC_W-1:0]          rr_ptr;
  logic [VC_W-1:0]          sel_vc;
  logic                     sel_found;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(`VR_VC_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // x first, then y
  function automatic logic [`VR_NUM_PORTS-1:0] xy_route(
    input flit_t                   f,
    input logic [`VR_COORD_W-1:0] x,
    input logic [`VR_COORD_W-1:0] y
  );
    logic [`VR_NUM_PORTS-1:0] dir_oh;
    dir_oh = '0;
    if (f.dst_x > x) dir_oh[dir_east] = 1'b1;
    else if (f.dst_x < x) dir_oh[dir_west] = 1'b1;
    else if (f.dst_y > y) dir_oh[dir_north] = 1'b1;
    else if (f.dst_y < y) dir_oh[dir_south] = 1'b1;
    else dir_oh[dir_local] = 1'b1;
    return dir_oh;
  endfunction

  // ==============================
  // vc fifos
  // ==============================

  for (genvar v = 0; v < `VR_NUM_VC; v++) begin : gen_vc
    assign push[v]      = data_v_i && (data_i.vc == VC_W'(v));
    assign pop[v]       = req.grant && (sel_vc == VC_W'(v));
    assign vc_empty[v]  = (count[v] == '0);
    assign head_flit[v] = mem[v][rd_ptr[v]];
    assign head_dir[v]  = xy_route(head_flit[v], my_x_i, my_y_i);
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int v = 0; v < `VR_NUM_VC; v++) begin
        wr_ptr[v] <= '0;
        rd_ptr[v] <= '0;
        count[v]  <= '0;
      end
    end else begin
      for (int v = 0; v < `VR_NUM_VC; v++) begin
        if (push[v]) wr_ptr[v] <= next_ptr(wr_ptr[v]);
        if (pop[v]) rd_ptr[v] <= next_ptr(rd_ptr[v]);
        // push and pop of one vc may meet in the same cycle
        count[v] <= count[v] + CNT_W'(push[v]) - CNT_W'(pop[v]);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int v = 0; v < `VR_NUM_VC; v++) begin
      if (push[v]) mem[v][wr_ptr[v]] <= data_i;
    end
  end

  // ==============================
  // local vc arbitration
  // ==============================

  always_comb begin
    int unsigned cand;
    sel_found = 1'b0;
    sel_vc    = rr_ptr;
    for (int k = 0; k < `VR_NUM_VC; k++) begin
      cand = (int'(rr_ptr) + k) % `VR_NUM_VC;
      if (!sel_found && !vc_empty[cand]) begin
        sel_found = 1'b1;
        sel_vc    = VC_W'(cand);
      end
    end
  end

  assign req.req_v      = sel_found;
  assign req.req_flit   = head_flit[sel_vc];
  assign req.req_dir_oh = head_dir[sel_vc];

  // pointer moves past the vc that was served
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_ptr     <= '0;
      credit_v_o <= 1'b0;
    end else begin
      credit_v_o <= req.grant;
      if (req.grant) begin
        rr_ptr <= (sel_vc == VC_W'(`VR_NUM_VC - 1)) ? '0 : sel_vc + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req.grant) credit_id_o <= sel_vc;
  end

  // upstream only sends with a credit in hand
  a_no_write_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    data_v_i |-> (count[data_i.vc] != CNT_W'(`VR_VC_DEPTH)));

  a_grant_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req.grant |-> (req.req_v && !$isunknown(req.grant_vc)));

endmodule

`default_nettype wire

//--- source/switch_allocator.sv
// switch allocator
// round-robin choice of one input per output, only for outputs that
// have a free downstream vc; assigns the lowest free vc to the winner

`timescale 1ns/1ps
`default_nettype none

`include "vc_router_macros.svh"

module switch_allocator (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  vc_req_if.allocator                                  req [`VR_NUM_PORTS],
  input  logic [`VR_NUM_PORTS-1:0][`VR_NUM_VC-1:0]     vc_free_i,
  output logic [`VR_NUM_PORTS-1:0]                     send_v_o,
  output logic [`VR_NUM_PORTS-1:0][`VR_VC_ID_W-1:0]    send_vc_o,
  output vc_router_pkg::flit_t [`VR_NUM_PORTS-1:0]     send_flit_o
);
  import vc_router_pkg::*;

  localparam int N      = `VR_NUM_PORTS;
  localparam int PORT_W = $clog2(`VR_NUM_PORTS);
  localparam int VC_W   = `VR_VC_ID_W;

  logic [N-1:0]                in_v;
  logic [N-1:0][N-1:0]         in_dir;
  flit_t [N-1:0]               in_flit;
  logic [N-1:0]                in_grant;
  logic [N-1:0][VC_W-1:0]      in_grant_vc;
  logic [N-1:0][PORT_W-1:0]    rr_ptr;
  logic [N-1:0][PORT_W-1:0]    winner;
  // gnt_mat[out][in]
  logic [N-1:0][N-1:0]         gnt_mat;

  // ==============================
  // request unpacking
  // ==============================

  for (genvar i = 0; i < N; i++) begin : gen_in
    assign in_v[i]         = req[i].req_v;
    assign in_dir[i]       = req[i].req_dir_oh;
    assign in_flit[i]      = req[i].req_flit;
    assign req[i].grant    = in_grant[i];
    assign req[i].grant_vc = in_grant_vc[i];
  end

  // ==============================
  // per-output arbitration
  // ==============================

  for (genvar o = 0; o < N; o++) begin : gen_out
    logic [N-1:0]      out_req;
    logic [PORT_W-1:0] win;
    logic              found;
    logic [VC_W-1:0]   free_vc;
    flit_t             win_flit;

    always_comb begin
      for (int i = 0; i < N; i++) begin
        out_req[i] = in_v[i] & in_dir[i][o];
      end
    end

    always_comb begin
      int unsigned cand;
      found = 1'b0;
      win   = rr_ptr[o];
      for (int k = 0; k < N; k++) begin
        cand = (int'(rr_ptr[o]) + k) % N;
        if (!found && out_req[cand]) begin
          found = 1'b1;
          win   = PORT_W'(cand);
        end
      end
    end

    // lowest numbered vc with a credit
    always_comb begin
      free_vc = '0;
      for (int v = `VR_NUM_VC - 1; v >= 0; v--) begin
        if (vc_free_i[o][v]) free_vc = VC_W'(v);
      end
    end

    always_comb begin
      win_flit    = in_flit[win];
      win_flit.vc = free_vc;
    end

    assign winner[o]      = win;
    assign send_v_o[o]    = found & (|vc_free_i[o]);
    assign send_vc_o[o]   = free_vc;
    assign send_flit_o[o] = win_flit;
    assign gnt_mat[o]     = send_v_o[o] ? (N'(1) << win) : '0;
  end

  // fold the per-output grants back onto the inputs
  always_comb begin
    in_grant    = '0;
    in_grant_vc = '0;
    for (int o = 0; o < N; o++) begin
      for (int i = 0; i < N; i++) begin
        if (gnt_mat[o][i]) begin
          in_grant[i]    = 1'b1;
          in_grant_vc[i] = send_vc_o[o];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_ptr <= '0;
    end else begin
      for (int o = 0; o < N; o++) begin
        if (send_v_o[o]) begin
          rr_ptr[o] <= (winner[o] == PORT_W'(N - 1)) ? '0 : winner[o] + 1'b1;
        end
      end
    end
  end

  // relies on every input asking for a single output at a time
  for (genvar i = 0; i < N; i++) begin : gen_chk
    logic [N-1:0] gnt_col;

    always_comb begin
      for (int o = 0; o < N; o++) begin
        gnt_col[o] = gnt_mat[o][i];
      end
    end

    a_one_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(gnt_col));
  end

endmodule

`default_nettype wire

//--- source/output_vc_tracker.sv
// output vc tracker
// counts free slots of each downstream vc from sends and returned credits

`timescale 1ns/1ps
`default_nettype none

`include "vc_router_macros.svh"

module output_vc_tracker (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   send_v_i,
  input  logic [`VR_VC_ID_W-1:0] send_vc_i,
  input  logic                   credit_v_i,
  input  logic [`VR_VC_ID_W-1:0] credit_id_i,
  output logic [`VR_NUM_VC-1:0]  vc_free_o
);

  localparam int CNT_W = `VR_CREDIT_W;
  localparam int VC_W  = `VR_VC_ID_W;

  logic [CNT_W-1:0]      cnt [`VR_NUM_VC];
  logic [`VR_NUM_VC-1:0] inc;
  logic [`VR_NUM_VC-1:0] dec;

  for (genvar v = 0; v < `VR_NUM_VC; v++) begin : gen_vc
    assign inc[v]       = credit_v_i && (credit_id_i == VC_W'(v));
    assign dec[v]       = send_v_i && (send_vc_i == VC_W'(v));
    assign vc_free_o[v] = (cnt[v] != '0);

    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (inc[v] && !dec[v]) |-> (cnt[v] < CNT_W'(`VR_VC_DEPTH)));

    a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (dec[v] && !inc[v]) |-> (cnt[v] != '0));
  end

  // ==============================
  // credit counters
  // ==============================

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int v = 0; v < `VR_NUM_VC; v++) begin
        cnt[v] <= CNT_W'(`VR_VC_DEPTH);
      end
    end else begin
      for (int v = 0; v < `VR_NUM_VC; v++) begin
        // a send and a credit on one vc cancel out
        cnt[v] <= cnt[v] + CNT_W'(inc[v]) - CNT_W'(dec[v]);
      end
    end
  end

endmodule

`default_nettype wire

//--- source/crossbar_stage.sv
// crossbar traversal stage
// registers the granted flit of every output and drives the links

`timescale 1ns/1ps
`default_nettype none

`include "vc_router_macros.svh"

module crossbar_stage (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  logic [`VR_NUM_PORTS-1:0]                 send_v_i,
  input  vc_router_pkg::flit_t [`VR_NUM_PORTS-1:0] send_flit_i,
  output logic [`VR_NUM_PORTS-1:0]                 data_v_o,
  output vc_router_pkg::flit_t [`VR_NUM_PORTS-1:0] data_o
);

  // ==============================
  // valid bits
  // ==============================

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      data_v_o <= '0;
    end else begin
      data_v_o <= send_v_i;
    end
  end

  // ==============================
  // flit registers
  // ==============================

  // only load on a send, the link holds its last flit otherwise
  always_ff @(posedge clk_i) begin
    for (int o = 0; o < `VR_NUM_PORTS; o++) begin
      if (send_v_i[o]) begin
        data_o[o] <= send_flit_i[o];
      end
    end
  end

endmodule

`default_nettype wire

//--- source/vc_router.sv
// vc mesh router top
// five input ports share the output links through one switch allocator,
// with per-output credit tracking and a registered crossbar

`timescale 1ns/1ps
`default_nettype none

`include "vc_router_macros.svh"

module vc_router (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  logic [`VR_COORD_W-1:0]                    my_x_i,
  input  logic [`VR_COORD_W-1:0]                    my_y_i,
  input  logic [`VR_NUM_PORTS-1:0]                  data_v_i,
  input  vc_router_pkg::flit_t [`VR_NUM_PORTS-1:0]  data_i,
  output logic [`VR_NUM_PORTS-1:0]                  credit_v_o,
  output logic [`VR_NUM_PORTS-1:0][`VR_VC_ID_W-1:0] credit_id_o,
  output logic [`VR_NUM_PORTS-1:0]                  data_v_o,
  output vc_router_pkg::flit_t [`VR_NUM_PORTS-1:0]  data_o,
  input  logic [`VR_NUM_PORTS-1:0]                  credit_v_i,
  input  logic [`VR_NUM_PORTS-1:0][`VR_VC_ID_W-1:0] credit_id_i
);
  import vc_router_pkg::*;

  logic [`VR_NUM_PORTS-1:0][`VR_NUM_VC-1:0]  vc_free;
  logic [`VR_NUM_PORTS-1:0]                  send_v;
  logic [`VR_NUM_PORTS-1:0][`VR_VC_ID_W-1:0] send_vc;
  flit_t [`VR_NUM_PORTS-1:0]                 send_flit;

  vc_req_if req_if [`VR_NUM_PORTS] ();

  // ==============================
  // input ports
  // ==============================

  for (genvar p = 0; p < `VR_NUM_PORTS; p++) begin : gen_in_port
    vc_input_port vc_input_port_i (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .my_x_i      (my_x_i),
      .my_y_i      (my_y_i),
      .data_v_i    (data_v_i[p]),
      .data_i      (data_i[p]),
      .credit_v_o  (credit_v_o[p]),
      .credit_id_o (credit_id_o[p]),
      .req         (req_if[p])
    );
  end

  // ==============================
  // allocation
  // ==============================

  switch_allocator switch_allocator_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req         (req_if),
    .vc_free_i   (vc_free),
    .send_v_o    (send_v),
    .send_vc_o   (send_vc),
    .send_flit_o (send_flit)
  );

  // one tracker per output link
  for (genvar o = 0; o < `VR_NUM_PORTS; o++) begin : gen_tracker
    output_vc_tracker output_vc_tracker_i (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .send_v_i    (send_v[o]),
      .send_vc_i   (send_vc[o]),
      .credit_v_i  (credit_v_i[o]),
      .credit_id_i (credit_id_i[o]),
      .vc_free_o   (vc_free[o])
    );
  end

  // ==============================
  // traversal
  // ==============================

  crossbar_stage crossbar_stage_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .send_v_i    (send_v),
    .send_flit_i (send_flit),
    .data_v_o    (data_v_o),
    .data_o      (data_o)
  );

endmodule

`default_nettype wire

//--- test/tb_vc_router.sv
// vc router testbench
// injects flits and credit holds from a data file, models upstream and
// downstream credits, checks routing, order, vc choice and fairness

`timescale 1ns/1ps
`default_nettype none

`include "vc_router_macros.svh"

module tb_vc_router;
  import vc_router_pkg::*;

  localparam int NP        = `VR_NUM_PORTS;
  localparam int NV        = `VR_NUM_VC;
  localparam int DEPTH     = `VR_VC_DEPTH;
  localparam int VC_W      = `VR_VC_ID_W;
  localparam int CW        = `VR_COORD_W;
  localparam int PW        = `VR_PAYLOAD_W;
  localparam int MAX_LINES = 64;
  localparam int RET_DELAY = 3;
  localparam int MAX_WAIT  = NP - 1;
  localparam int MY_X      = 2;
  localparam int MY_Y      = 2;

  logic                      clk_i;
  logic                      rst_n_i;
  logic [CW-1:0]             my_x_i;
  logic [CW-1:0]             my_y_i;
  logic [NP-1:0]             data_v_i;
  flit_t [NP-1:0]            data_i;
  logic [NP-1:0]             credit_v_o;
  logic [NP-1:0][VC_W-1:0]   credit_id_o;
  logic [NP-1:0]             data_v_o;
  flit_t [NP-1:0]            data_o;
  logic [NP-1:0]             credit_v_i;
  logic [NP-1:0][VC_W-1:0]   credit_id_i;

  // stimulus table
  logic is_hold [MAX_LINES];
  int   ln_port [MAX_LINES];
  int   ln_vc [MAX_LINES];
  int   ln_dx [MAX_LINES];
  int   ln_dy [MAX_LINES];
  int   ln_pl [MAX_LINES];
  int   ln_hold [MAX_LINES];
  int   n_lines;
  int   hold_total;

  // credit models, upstream side and downstream side
  int            in_cred [NP][NV];
  int            ds_cred [NP][NV];
  int            ret_q [NP][$];
  int            hold_left [NP];
  logic [NP-1:0] cred_last_v;
  int            cred_last_vc [NP];

  // scoreboard and local output wait tracking
  flit_t sb_q [NP][$];
  int    loc_out [NP];
  int    loc_new [NP];
  int    loc_wait [NP];

  int errors;
  int checks;
  int cycle;
  int injected;
  int limit;
  int idx;
  int gap;

  vc_router vc_router_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .my_x_i      (my_x_i),
    .my_y_i      (my_y_i),
    .data_v_i    (data_v_i),
    .data_i      (data_i),
    .credit_v_o  (credit_v_o),
    .credit_id_o (credit_id_o),
    .data_v_o    (data_v_o),
    .data_o      (data_o),
    .credit_v_i  (credit_v_i),
    .credit_id_i (credit_id_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // ==============================
  // reference rules
  // ==============================

  // x first, then y, local when both match
  function automatic int route_xy(input int dx, input int dy);
    if (dx > MY_X) return int'(dir_east);
    if (dx < MY_X) return int'(dir_west);
    if (dy > MY_Y) return int'(dir_north);
    if (dy < MY_Y) return int'(dir_south);
    return int'(dir_local);
  endfunction

  function automatic int lowest_free_vc(input int o);
    for (int v = 0; v < NV; v++) begin
      if (ds_cred[o][v] > 0) return v;
    end
    return -1;
  endfunction

  function automatic logic traffic_drained();
    if (idx < n_lines) return 1'b0;
    for (int o = 0; o < NP; o++) begin
      if (sb_q[o].size() != 0 || ret_q[o].size() != 0) return 1'b0;
      if (hold_left[o] != 0 || cred_last_v[o]) return 1'b0;
      for (int v = 0; v < NV; v++) begin
        if (in_cred[o][v] != DEPTH || ds_cred[o][v] != DEPTH) return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic load_stimulus();
    int          fd;
    int          n;
    string       line;
    logic [31:0] cmd;
    int          p, v, dx, dy, pl, h;
    n_lines    = 0;
    hold_total = 0;
    fd = $fopen("test/vc_router_input.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file");
      errors++;
      return;
    end
    while (!$feof(fd) && n_lines < MAX_LINES) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.getc(0) == "#") continue;
      n = $sscanf(line, "%s %d %d %d %d %h %d", cmd, p, v, dx, dy, pl, h);
      if (n != 7) continue;
      if (cmd != "flit" && cmd != "hold") begin
        $display("unknown command in the stimulus file");
        errors++;
        continue;
      end
      is_hold[n_lines] = (cmd == "hold");
      ln_port[n_lines] = p;
      ln_vc[n_lines]   = v;
      ln_dx[n_lines]   = dx;
      ln_dy[n_lines]   = dy;
      ln_pl[n_lines]   = pl;
      ln_hold[n_lines] = h;
      if (cmd == "hold") hold_total += h;
      n_lines++;
    end
    $fclose(fd);
  endtask

  // ==============================
  // output side
  // ==============================

  task automatic match_flit(input int o, input flit_t f);
    flit_t e;
    int    hit;
    logic  order_bad;
    hit       = -1;
    order_bad = 1'b0;
    for (int i = 0; i < sb_q[o].size(); i++) begin
      e = sb_q[o][i];
      if (hit < 0 && e.payload == f.payload) hit = i;
    end
    if (hit < 0) begin
      $display("[FAIL] xy_route payload %h: expected port %0d actual port %0d",
               f.payload, route_xy(int'(f.dst_x), int'(f.dst_y)), o);
      errors++;
      return;
    end
    e = sb_q[o][hit];
    if (f.src_port != e.src_port) begin
      $display("[FAIL] src_port payload %h: expected %0d actual %0d",
               f.payload, e.src_port, f.src_port);
      errors++;
    end
    if (f.dst_x != e.dst_x || f.dst_y != e.dst_y) begin
      $display("[FAIL] dst payload %h: expected %0d,%0d actual %0d,%0d",
               f.payload, e.dst_x, e.dst_y, f.dst_x, f.dst_y);
      errors++;
    end
    // an older flit of the same input vc must leave first
    for (int i = 0; i < hit; i++) begin
      if (!order_bad && sb_q[o][i].src_port == e.src_port && sb_q[o][i].vc == e.vc) begin
        order_bad = 1'b1;
        $display("[FAIL] order output %0d: expected %h actual %h",
                 o, sb_q[o][i].payload, f.payload);
        errors++;
      end
    end
    sb_q[o].delete(hit);
  endtask

  task automatic track_fairness(input int s);
    for (int p = 0; p < NP; p++) begin
      if (p == s) begin
        loc_wait[p] = 0;
        if (loc_out[p] > 0) loc_out[p]--;
      end else if (loc_out[p] > 0) begin
        loc_wait[p]++;
        if (loc_wait[p] == MAX_WAIT + 1) begin
          $display("[FAIL] fairness port %0d: expected at most %0d actual %0d",
                   p, MAX_WAIT, loc_wait[p]);
          errors++;
        end
      end
    end
  endtask

  task automatic scan_outputs();
    flit_t f;
    int    exp_vc;
    for (int o = 0; o < NP; o++) begin
      if (data_v_o[o]) begin
        f = data_o[o];
        checks++;
        exp_vc = lowest_free_vc(o);
        if (exp_vc < 0) begin
          $display("output %0d sent a flit without a downstream credit", o);
          errors++;
        end else begin
          if (int'(f.vc) != exp_vc) begin
            $display("[FAIL] vc_assign output %0d: expected %0d actual %0d", o, exp_vc, f.vc);
            errors++;
          end
          if (ds_cred[o][f.vc] > 0) ds_cred[o][f.vc]--;
          ret_q[o].push_back((cycle + RET_DELAY) * NV + int'(f.vc));
        end
        match_flit(o, f);
        if (o == int'(dir_local)) track_fairness(int'(f.src_port));
      end
    end
  endtask

  // the dut counter sees a returned credit one edge after it is driven
  task automatic absorb_returned_credits();
    for (int o = 0; o < NP; o++) begin
      if (cred_last_v[o]) ds_cred[o][cred_last_vc[o]]++;
    end
  endtask

  task automatic return_credits();
    int e;
    credit_v_i  = '0;
    credit_id_i = '0;
    for (int o = 0; o < NP; o++) begin
      cred_last_v[o] = 1'b0;
      if (hold_left[o] > 0) begin
        hold_left[o]--;
      end else if (ret_q[o].size() > 0 && ret_q[o][0] / NV <= cycle) begin
        e               = ret_q[o].pop_front();
        credit_v_i[o]   = 1'b1;
        credit_id_i[o]  = VC_W'(e % NV);
        cred_last_v[o]  = 1'b1;
        cred_last_vc[o] = e % NV;
      end
    end
  endtask

  // ==============================
  // input side
  // ==============================

  task automatic collect_input_credits();
    int v;
    for (int p = 0; p < NP; p++) begin
      if (credit_v_o[p]) begin
        v = int'(credit_id_o[p]);
        checks++;
        if (in_cred[p][v] >= DEPTH) begin
          $display("input port %0d returned a credit on vc %0d that was never used", p, v);
          errors++;
        end else begin
          in_cred[p][v]++;
        end
      end
    end
  endtask

  // a local flit starts waiting once the dut has taken it in
  task automatic arm_wait_tracking();
    for (int p = 0; p < NP; p++) begin
      loc_out[p] += loc_new[p];
      loc_new[p] = 0;
    end
  endtask

  // one line per input port per cycle, stops at a hold or a missing credit
  task automatic inject_flits();
    logic [NP-1:0] taken;
    logic          stop;
    flit_t         f;
    int            p;
    int            v;
    int            dest;
    data_v_i = '0;
    taken    = '0;
    stop     = 1'b0;
    if (gap > 0) begin
      gap--;
      return;
    end
    while (!stop && idx < n_lines) begin
      p = ln_port[idx];
      v = ln_vc[idx];
      if (is_hold[idx]) begin
        hold_left[p] = ln_hold[idx];
        idx++;
        stop = 1'b1;
      end else if (taken[p] || in_cred[p][v] == 0) begin
        stop = 1'b1;
      end else begin
        f.vc       = VC_W'(v);
        f.dst_x    = CW'(ln_dx[idx]);
        f.dst_y    = CW'(ln_dy[idx]);
        f.src_port = port_dir_e'(p);
        f.payload  = PW'(ln_pl[idx]);
        data_i[p]   = f;
        data_v_i[p] = 1'b1;
        taken[p]    = 1'b1;
        in_cred[p][v]--;
        dest = route_xy(ln_dx[idx], ln_dy[idx]);
        sb_q[dest].push_back(f);
        if (dest == int'(dir_local)) loc_new[p]++;
        injected++;
        idx++;
      end
    end
    if (taken != '0) gap = int'($urandom % 3);
  endtask

  // ==============================
  // main sequence
  // ==============================

  initial begin
    void'($urandom(32'he16f));
    errors      = 0;
    checks      = 0;
    cycle       = 0;
    injected    = 0;
    idx         = 0;
    gap         = 0;
    rst_n_i     = 1'b0;
    my_x_i      = CW'(MY_X);
    my_y_i      = CW'(MY_Y);
    data_v_i    = '0;
    data_i      = '0;
    credit_v_i  = '0;
    credit_id_i = '0;
    cred_last_v = '0;
    for (int p = 0; p < NP; p++) begin
      hold_left[p]    = 0;
      cred_last_vc[p] = 0;
      loc_out[p]      = 0;
      loc_new[p]      = 0;
      loc_wait[p]     = 0;
      for (int v = 0; v < NV; v++) begin
        in_cred[p][v] = DEPTH;
        ds_cred[p][v] = DEPTH;
      end
    end

    load_stimulus();
    if (n_lines == 0) begin
      $display("no stimulus lines were read");
      errors++;
    end
    limit = 40 * n_lines + hold_total;

    repeat (8) begin
      @(posedge clk_i);
      #1;
      if (data_v_o !== '0 || credit_v_o !== '0) begin
        $display("outputs were active during reset");
        errors++;
      end
    end
    rst_n_i = 1'b1;

    while (!traffic_drained() && cycle < limit) begin
      @(posedge clk_i);
      #1;
      cycle++;
      if (injected == 0 && (data_v_o != '0 || credit_v_o != '0)) begin
        $display("outputs went active before any flit was sent");
        errors++;
      end
      scan_outputs();
      absorb_returned_credits();
      collect_input_credits();
      arm_wait_tracking();
      return_credits();
      inject_flits();
    end

    if (!traffic_drained()) begin
      $display("timeout after %0d cycles with traffic still in flight", cycle);
      errors++;
    end
    for (int o = 0; o < NP; o++) begin
      if (sb_q[o].size() != 0) begin
        $display("[FAIL] drain output %0d: expected 0 actual %0d", o, sb_q[o].size());
        errors++;
      end
      for (int v = 0; v < NV; v++) begin
        if (in_cred[o][v] != DEPTH) begin
          $display("[FAIL] credit_restore port %0d vc %0d: expected %0d actual %0d",
                   o, v, DEPTH, in_cred[o][v]);
          errors++;
        end
      end
    end

    $display("flits %0d checks %0d errors %0d", injected, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vc_router.f
+incdir+.
source/vc_router_pkg.sv
source/vc_req_if.sv
source/vc_input_port.sv
source/switch_allocator.sv
source/output_vc_tracker.sv
source/crossbar_stage.sv
source/vc_router.sv
test/tb_vc_router.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the vc router testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f vc_router.f \
  --top-module tb_vc_router -o sim_vc_router > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_vc_router > sim.log 2>&1 || true
cat sim.log
grep -q "^STATUS: PASS$" sim.log && echo "simulation passed" && exit 0 \
  || { echo "simulation failed"; exit 1; }

//--- test/vc_router_input.txt
# cmd port vc dst_x dst_y payload_hex hold_cycles   (router sits at 2,2)
# flit injects on an input port and vc, hold stalls the credits of an output port
flit 4 0 3 2 0101 0
flit 0 1 1 2 0102 0
flit 1 0 2 3 0103 0
flit 3 1 2 0 0104 0
flit 2 0 2 2 0105 0
flit 4 1 0 5 0106 0
flit 2 1 2 6 0107 0
flit 2 1 2 4 0108 0
flit 2 1 2 3 0109 0
flit 0 0 2 2 0301 0
flit 1 0 2 2 0302 0
flit 2 0 2 2 0303 0
flit 3 0 2 2 0304 0
flit 4 0 2 2 0305 0
flit 0 1 2 2 0306 0
flit 1 1 2 2 0307 0
flit 2 1 2 2 0308 0
flit 3 1 2 2 0309 0
flit 4 1 2 2 030a 0
flit 0 0 2 2 030b 0
flit 1 0 2 2 030c 0
flit 2 0 2 2 030d 0
flit 3 0 2 2 030e 0
flit 4 0 2 2 030f 0
hold 1 0 0 0 0000 25
flit 3 0 4 2 0201 0
flit 3 1 5 1 0202 0
flit 3 0 3 3 0203 0
flit 3 1 7 2 0204 0
flit 3 0 6 0 0205 0
